// ==== list.f ====
vga_pkg.sv
plot_pkg.sv
column_plotter.sv
plot_arbiter.sv
pixel_plotter_top.sv
tb_pixel_plotter.sv

// ==== Makefile ====
# Verilator build and run of the pixel plotter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pixel_plotter
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_pixel_plotter.sv ====
//////////////////////////////////////////////////
// Testbench for the column plotter bank: random
// requests, write model, handshake checks, watchdog
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_pixel_plotter;

	localparam int                NUM_COLS       = 8;
	localparam vga_pkg::fb_addr_t FB_BASE        = 32'h0800_0000;
	localparam int                ROUNDS         = 40;
	localparam int                RESET_CYCLES   = 16;
	localparam int                TIMEOUT_CYCLES = ROUNDS * NUM_COLS * 8 + RESET_CYCLES;

	logic                CLOCK_50;
	logic                rst_n;
	logic [NUM_COLS-1:0] col_select;
	vga_pkg::row_t       row_select;
	vga_pkg::pixel_t     pixel_color;
	logic [NUM_COLS-1:0] col_done;
	vga_pkg::fb_write_t  fb_wr;
	logic                fb_wr_strobe;

	// Model state per column
	vga_pkg::fb_write_t  exp_wr [NUM_COLS];
	logic [NUM_COLS-1:0] written;
	logic [NUM_COLS-1:0] sel_prev;
	logic [NUM_COLS-1:0] done_prev;
	logic                prev_strobe;
	logic [31:0]         rng;

	int outstanding;
	int requests;
	int writes;
	int batches;
	int data_errs;
	int order_errs;
	int hs_errs;

	pixel_plotter_top #(
		.NUM_COLS (NUM_COLS),
		.FB_BASE  (FB_BASE)
	) pixel_plotter_top_inst (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.col_select   (col_select),
		.row_select   (row_select),
		.pixel_color  (pixel_color),
		.col_done     (col_done),
		.fb_wr        (fb_wr),
		.fb_wr_strobe (fb_wr_strobe)
	);

	// 50 MHz
	always #10 CLOCK_50 = ~CLOCK_50;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// 32-bit xorshift step
	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Buffer address of one plotted pixel
	function automatic vga_pkg::fb_addr_t expected_addr(input int col, input vga_pkg::row_t row);
		vga_pkg::fb_addr_t line;
		line = vga_pkg::fb_addr_t'((int'(row) + vga_pkg::Y_OFFSET) * vga_pkg::SCREEN_WIDTH);
		return FB_BASE + vga_pkg::fb_addr_t'(col + vga_pkg::X_OFFSET) + line;
	endfunction

	// Column recovered from the x part of an address
	function automatic int column_of(input vga_pkg::fb_addr_t addr);
		vga_pkg::fb_addr_t off;
		off = addr - FB_BASE - vga_pkg::fb_addr_t'(vga_pkg::X_OFFSET);
		return int'(off % vga_pkg::fb_addr_t'(vga_pkg::SCREEN_WIDTH));
	endfunction

	// One strobe, matched against the open requests
	task automatic check_write();
		int c;
		c = column_of(fb_wr.addr);
		if (c >= NUM_COLS) begin
			$display("Write to address %h belongs to no plotted column", fb_wr.addr);
			order_errs++;
		end else if (!col_select[c] || written[c]) begin
			$display("Column %0d was written without an open request", c);
			order_errs++;
		end else begin
			if (fb_wr != exp_wr[c]) begin
				$display("FAIL write_data col %0d: expected %h actual %h", c, exp_wr[c], fb_wr);
				data_errs++;
			end
			written[c] = 1'b1;
			outstanding--;
		end
		writes++;
	endtask

	// Checks on the outputs, once per cycle at the falling edge
	task automatic check_cycle();
		if (fb_wr_strobe) begin
			if (prev_strobe) begin
				$display("Two buffer writes came in consecutive cycles");
				order_errs++;
			end
			check_write();
		end
		prev_strobe = fb_wr_strobe;
		for (int c = 0; c < NUM_COLS; c++) begin
			// Done only after the write went out
			if (col_done[c] && !written[c]) begin
				$display("Column %0d raised col_done before its write", c);
				hs_errs++;
			end
			// Done holds while the select is still seen high
			if (done_prev[c] && !col_done[c] && sel_prev[c]) begin
				$display("Column %0d dropped col_done while col_select was still high", c);
				hs_errs++;
			end
			// Done drops one cycle after the select
			if (col_done[c] && !col_select[c] && !sel_prev[c]) begin
				$display("Column %0d kept col_done high after col_select fell", c);
				hs_errs++;
			end
		end
		sel_prev  = col_select;
		done_prev = col_done;
	endtask

	//////////////////////////////////////////////////
	// Stimulus and model
	//////////////////////////////////////////////////

	initial begin : stimulus
		logic [NUM_COLS-1:0] next_sel;
		logic [NUM_COLS-1:0] raise;
		vga_pkg::row_t       row;
		vga_pkg::pixel_t     color;
		logic                running;
		CLOCK_50    = 1'b0;
		rst_n       = 1'b0;
		col_select  = '0;
		row_select  = '0;
		pixel_color = '0;
		written     = '0;
		sel_prev    = '0;
		done_prev   = '0;
		prev_strobe = 1'b0;
		rng         = 32'd55730;
		outstanding = 0;
		requests    = 0;
		writes      = 0;
		batches     = 0;
		data_errs   = 0;
		order_errs  = 0;
		hs_errs     = 0;
		row         = '0;
		color       = '0;

		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		rst_n <= 1'b1;

		// Quiet outputs out of reset
		repeat (2) begin
			@(negedge CLOCK_50);
			if (col_done !== '0) begin
				$display("FAIL reset_done: expected %h actual %h", {NUM_COLS{1'b0}}, col_done);
				hs_errs++;
			end
			if (fb_wr_strobe !== 1'b0) begin
				$display("FAIL reset_strobe: expected 0 actual %b", fb_wr_strobe);
				order_errs++;
			end
		end

		running = 1'b1;
		while (running) begin
			@(negedge CLOCK_50);
			check_cycle();
			if (batches >= ROUNDS && col_select == '0 && col_done == '0) begin
				running = 1'b0;
			end else begin
				// Let go of columns that reported done
				next_sel = col_select & ~col_done;
				raise    = '0;
				if (batches < ROUNDS) begin
					rng   = next_rand(rng);
					raise = rng[NUM_COLS-1:0] & ~col_select & ~col_done;
				end
				if (raise != '0) begin
					rng   = next_rand(rng);
					row   = rng[9:0];
					color = rng[17:10];
					for (int c = 0; c < NUM_COLS; c++) begin
						if (raise[c]) begin
							exp_wr[c].addr  = expected_addr(c, row);
							exp_wr[c].color = color;
							written[c]      = 1'b0;
							requests++;
							outstanding++;
						end
					end
					batches++;
				end
				@(posedge CLOCK_50);
				col_select <= next_sel | raise;
				if (raise != '0) begin
					row_select  <= row;
					pixel_color <= color;
				end
			end
		end

		// No stray writes once all columns are idle
		repeat (4) begin
			@(negedge CLOCK_50);
			check_cycle();
		end

		if (writes != requests) begin
			$display("FAIL write_count: expected %0d actual %0d", requests, writes);
			order_errs++;
		end
		if (outstanding != 0) begin
			$display("%0d requests were never written", outstanding);
			order_errs++;
		end

		$display("Errors: data %0d, order %0d, handshake %0d, total %0d (%0d writes)",
			data_errs, order_errs, hs_errs, data_errs + order_errs + hs_errs, writes);
		if (data_errs + order_errs + hs_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge CLOCK_50);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pixel_plotter_top.sv ====
//////////////////////////////////////////////////
// Column plotter bank and write arbiter
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module pixel_plotter_top #(
	parameter int                NUM_COLS = 100,
	parameter vga_pkg::fb_addr_t FB_BASE  = '0
) (
	input  logic                CLOCK_50,
	input  logic                rst_n,
	input  logic [NUM_COLS-1:0] col_select,
	input  vga_pkg::row_t       row_select,
	input  vga_pkg::pixel_t     pixel_color,
	output logic [NUM_COLS-1:0] col_done,
	output vga_pkg::fb_write_t  fb_wr,
	output logic                fb_wr_strobe
);

	// One request per column, gathered for the arbiter
	plot_pkg::col_req_t  reqs [NUM_COLS];

	// One-cycle ack back to each column
	logic [NUM_COLS-1:0] grant_ack;

	//////////////////////////////////////////////////
	// Column plotters
	//////////////////////////////////////////////////

	// Row and colour are shared
	// each column samples them on its own select
	for (genvar i = 0; i < NUM_COLS; i++) begin : gen_col
		column_plotter #(
			.COL_INDEX (i),
			.FB_BASE   (FB_BASE)
		) column_plotter_inst (
			.CLOCK_50    (CLOCK_50),
			.rst_n       (rst_n),
			.col_select  (col_select[i]),
			.row_select  (row_select),
			.pixel_color (pixel_color),
			.grant_ack   (grant_ack[i]),
			.req         (reqs[i]),
			.col_done    (col_done[i])
		);
	end

	//////////////////////////////////////////////////
	// Write arbiter
	//////////////////////////////////////////////////

	// Owns the single pixel-buffer write port
	plot_arbiter #(
		.NUM_COLS (NUM_COLS)
	) plot_arbiter_inst (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.reqs         (reqs),
		.grant_ack    (grant_ack),
		.fb_wr        (fb_wr),
		.fb_wr_strobe (fb_wr_strobe)
	);

endmodule

`default_nettype wire

// ==== plot_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin arbiter for the single buffer write
// port, one grant per two cycles at most
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module plot_arbiter #(
	parameter int NUM_COLS = 100
) (
	input  logic                CLOCK_50,
	input  logic                rst_n,
	input  plot_pkg::col_req_t  reqs [NUM_COLS],
	output logic [NUM_COLS-1:0] grant_ack,
	output vga_pkg::fb_write_t  fb_wr,
	output logic                fb_wr_strobe
);

	// Width of a column index
	localparam int IDX_W = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

	plot_pkg::arb_state_t state_q;
	logic [IDX_W-1:0]     last_q;
	logic [IDX_W-1:0]     win_q;
	logic                 mask_q;
	vga_pkg::fb_write_t   wr_q;

	logic                 found;
	logic [IDX_W-1:0]     pick;

	//////////////////////////////////////////////////
	// Round-robin search
	//////////////////////////////////////////////////

	// Start just past the last grant and wrap
	// The column acked last cycle is skipped once
	always_comb begin : search_blk
		int idx;
		found = 1'b0;
		pick  = '0;
		for (int k = 0; k < NUM_COLS; k++) begin
			idx = int'(last_q) + 1 + k;
			if (idx >= NUM_COLS) begin
				idx = idx - NUM_COLS;
			end
			if (!found && reqs[idx].pending
				&& !(mask_q && idx == int'(last_q))) begin
				found = 1'b1;
				pick  = IDX_W'(idx);
			end
		end
	end

	//////////////////////////////////////////////////
	// Grant FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= plot_pkg::ARB_SCAN;
			last_q  <= IDX_W'(NUM_COLS - 1);
			win_q   <= '0;
			mask_q  <= 1'b0;
		end else begin
			case (state_q)
				plot_pkg::ARB_SCAN: begin
					// Mask only lasts for the first scan cycle
					mask_q <= 1'b0;
					if (found) begin
						win_q   <= pick;
						state_q <= plot_pkg::ARB_ACK;
					end
				end
				plot_pkg::ARB_ACK: begin
					// Write issued, move the pointer
					last_q  <= win_q;
					mask_q  <= 1'b1;
					state_q <= plot_pkg::ARB_SCAN;
				end
			endcase
		end
	end

	// Winner's write, captured with the grant
	always_ff @(posedge CLOCK_50) begin
		if (state_q == plot_pkg::ARB_SCAN && found) begin
			wr_q <= reqs[pick].wr;
		end
	end

	//////////////////////////////////////////////////
	// Write port and acks
	//////////////////////////////////////////////////

	// Strobe and ack share the ARB_ACK cycle
	always_comb begin
		grant_ack = '0;
		if (state_q == plot_pkg::ARB_ACK) begin
			grant_ack[win_q] = 1'b1;
		end
	end

	assign fb_wr_strobe = (state_q == plot_pkg::ARB_ACK);
	assign fb_wr        = wr_q;

endmodule

`default_nettype wire

// ==== column_plotter.sv ====
//////////////////////////////////////////////////
// Per-column FSM, pixel address former, and the
// reader and arbiter handshakes
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module column_plotter #(
	parameter int                 COL_INDEX = 0,
	parameter vga_pkg::fb_addr_t  FB_BASE   = '0
) (
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              col_select,
	input  vga_pkg::row_t     row_select,
	input  vga_pkg::pixel_t   pixel_color,
	input  logic              grant_ack,
	output plot_pkg::col_req_t req,
	output logic              col_done
);

	// This column's x position inside the plotting area
	localparam vga_pkg::col_idx_t COL_X = vga_pkg::col_idx_t'(COL_INDEX);

	plot_pkg::col_state_t state_q;
	logic                 pend_q;
	vga_pkg::fb_write_t   wr_q;
	vga_pkg::fb_addr_t    next_addr;

	//////////////////////////////////////////////////
	// Address former
	//////////////////////////////////////////////////

	// base + (x + x_off) + (row + y_off) * line width
	always_comb begin
		next_addr = FB_BASE
			+ vga_pkg::fb_addr_t'(COL_X)
			+ vga_pkg::fb_addr_t'(vga_pkg::X_OFFSET)
			+ (vga_pkg::fb_addr_t'(row_select)
				+ vga_pkg::fb_addr_t'(vga_pkg::Y_OFFSET))
			* vga_pkg::fb_addr_t'(vga_pkg::SCREEN_WIDTH);
	end

	//////////////////////////////////////////////////
	// Column FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= plot_pkg::COL_IDLE;
			pend_q   <= 1'b0;
			col_done <= 1'b0;
		end else begin
			case (state_q)
				plot_pkg::COL_IDLE: begin
					// Selected by the reader, raise the request
					if (col_select) begin
						pend_q  <= 1'b1;
						state_q <= plot_pkg::COL_REQ;
					end
				end
				plot_pkg::COL_REQ: begin
					// Write went out this cycle
					if (grant_ack) begin
						pend_q   <= 1'b0;
						col_done <= 1'b1;
						state_q  <= plot_pkg::COL_DONE;
					end
				end
				plot_pkg::COL_DONE: begin
					// Hold done until the reader lets go
					if (!col_select) begin
						col_done <= 1'b0;
						state_q  <= plot_pkg::COL_IDLE;
					end
				end
				default: begin
					state_q  <= plot_pkg::COL_IDLE;
					pend_q   <= 1'b0;
					col_done <= 1'b0;
				end
			endcase
		end
	end

	// Address and colour latched once, when leaving idle
	always_ff @(posedge CLOCK_50) begin
		if (state_q == plot_pkg::COL_IDLE && col_select) begin
			wr_q.addr  <= next_addr;
			wr_q.color <= pixel_color;
		end
	end

	// Request toward the arbiter
	assign req.pending = pend_q;
	assign req.wr      = wr_q;

endmodule

`default_nettype wire

// ==== plot_pkg.sv ====
//////////////////////////////////////////////////
// Column and arbiter state enums, column request
//////////////////////////////////////////////////

`default_nettype none

package plot_pkg;

	// Column plotter states
	// Idle until selected, then wait for the write, then report done
	typedef enum logic [1:0] {
		COL_IDLE = 2'd0,
		COL_REQ  = 2'd1,
		COL_DONE = 2'd2
	} col_state_t;

	// Arbiter states
	// Scan picks a winner, ack issues its write
	typedef enum logic {
		ARB_SCAN = 1'b0,
		ARB_ACK  = 1'b1
	} arb_state_t;

	// Request held by one column toward the arbiter
	// Address and colour stay fixed while pending is high
	typedef struct packed {
		logic              pending;
		vga_pkg::fb_write_t wr;
	} col_req_t;

endpackage

`default_nettype wire

// ==== vga_pkg.sv ====
//////////////////////////////////////////////////
// Pixel-buffer geometry, address and colour types
// and the single buffer write struct
//////////////////////////////////////////////////

`default_nettype none

package vga_pkg;

	//////////////////////////////////////////////////
	// Screen geometry
	//////////////////////////////////////////////////

	// Pixels per buffer line
	localparam int SCREEN_WIDTH = 640;

	// Corner of the plotting area on screen
	localparam int X_OFFSET = 100;
	localparam int Y_OFFSET = 100;

	//////////////////////////////////////////////////
	// Basic types
	//////////////////////////////////////////////////

	// Row number from the reader
	typedef logic [9:0] row_t;

	// Column index inside the plotting area
	typedef logic [9:0] col_idx_t;

	// Byte address into the pixel buffer
	typedef logic [31:0] fb_addr_t;

	// 8-bit colour, one byte per pixel
	typedef logic [7:0] pixel_t;

	// One buffer write, address above colour
	typedef struct packed {
		fb_addr_t addr;
		pixel_t   color;
	} fb_write_t;

endpackage

`default_nettype wire
